// ==== src/coreTypesPkg.sv ====
package coreTypesPkg;

    // Instruction number carried with every operation
    localparam int tagWidth = 32;

    typedef logic [tagWidth-1:0] instTag;

    // Completions waiting for the result bus
    localparam int resultQueueDepth = 4;

    // One load or store as handed over by the issue stage
    typedef struct packed {
        instTag      tag;       // Instruction number
        logic [2:0]  funct3;    // Access size and signedness
        logic        isStore;   // Store when set, load otherwise
        logic [31:0] base;      // rs1 value
        logic [31:0] offset;    // Sign-extended immediate
        logic [31:0] storeData; // rs2 value, ignored for loads
    } lsRequest;

    // One finished operation as driven onto the result bus
    typedef struct packed {
        instTag      tag;     // Instruction number, unchanged from issue
        logic [31:0] data;    // Extended load value, zero for stores and faults
        logic        isStore; // Echo of the request kind
        logic        fault;   // Misaligned or illegal access
    } lsResult;

endpackage

// ==== src/memPkg.sv ====
package memPkg;

    import coreTypesPkg::*;

    // Data memory geometry
    localparam int memWords      = 2048;
    localparam int memIndexWidth = 11;

    // Accesses waiting for the memory
    localparam int accessQueueDepth = 4;

    // funct3 access codes
    localparam logic [2:0] sizeByte  = 3'b000;
    localparam logic [2:0] sizeHalf  = 3'b001;
    localparam logic [2:0] sizeWord  = 3'b010;
    localparam logic [2:0] sizeByteU = 3'b100;
    localparam logic [2:0] sizeHalfU = 3'b101;

    // Decoded access, from the address unit to the data memory
    typedef struct packed {
        instTag                   tag;        // Instruction number
        logic [2:0]               funct3;     // Access code
        logic                     isStore;    // Store when set
        logic [memIndexWidth-1:0] wordIndex;  // Address bits 12:2
        logic [1:0]               byteOffset; // Address bits 1:0
        logic [31:0]              storeData;  // Unaligned store value
        logic                     fault;      // Access must not touch memory
    } memAccess;

endpackage

// ==== src/addressUnit.sv ====
`timescale 1ns/1ns

module addressUnit
    import coreTypesPkg::*, memPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     issue,
    input  lsRequest request,
    output logic     accessValid,
    output memAccess access
);

    logic [31:0] address;
    logic        badAccess;

    assign address = request.base + request.offset; // Effective address

    // Alignment and code check on the unregistered address
    always_comb begin
        case (request.funct3)
            sizeByte, sizeByteU: begin
                badAccess = 1'b0;
            end
            sizeHalf, sizeHalfU: begin
                badAccess = address[0]; // Odd halfword
            end
            sizeWord: begin
                badAccess = |address[1:0]; // Word not on a 4-byte boundary
            end
            default: begin
                badAccess = 1'b1; // No such access code
            end
        endcase
    end

    // Strobe for the access queue
    always_ff @(posedge clk) begin
        if (reset) begin
            accessValid <= 1'b0;
        end else begin
            accessValid <= issue;
        end
    end

    // Decoded access, loaded only on an accepted issue
    always_ff @(posedge clk) begin
        if (issue) begin
            access.tag        <= request.tag;
            access.funct3     <= request.funct3;
            access.isStore    <= request.isStore;
            access.wordIndex  <= address[memIndexWidth+1:2]; // Upper bits dropped
            access.byteOffset <= address[1:0];
            access.storeData  <= request.storeData;
            access.fault      <= badAccess;
        end
    end

endmodule

// ==== src/opQueue.sv ====
`timescale 1ns/1ns

module opQueue #(
    parameter type payloadType = logic,
    parameter int  depth       = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  payloadType pushData,
    input  logic       pop,
    output payloadType headData,
    output logic       empty,
    output logic       full,
    output logic       almostFull
);

    payloadType slots [depth];

    logic [$clog2(depth)-1:0]   rdPtr;
    logic [$clog2(depth)-1:0]   wrPtr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       doPop;

    assign doPop      = pop && !empty;
    assign empty      = (count == 0);
    assign full       = (count == depth);
    assign almostFull = (count >= depth - 1); // One free slot or none
    assign headData   = slots[rdPtr];        // Head readable without delay

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wrPtr] <= pushData;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
            end
            case ({push, doPop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count; // Idle or push with pop
                end
            endcase
        end
    end

endmodule

// ==== src/dataMemory.sv ====
`timescale 1ns/1ns

module dataMemory
    import coreTypesPkg::*, memPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     accessEmpty,
    input  memAccess access,
    input  logic     resultFull,
    output logic     accessTake,
    output logic     sweepDone,
    output logic     doneValid,
    output lsResult  done
);

    logic [3:0][7:0] mem [memWords]; // Word array with byte lanes

    logic [memIndexWidth-1:0] sweepIdx;
    logic [memIndexWidth-1:0] writeIndex;
    logic [3:0][7:0]          writeWord;
    logic [3:0]               writeLanes;
    logic [3:0][7:0]          laneData;
    logic [3:0]               storeLanes;
    logic [3:0][7:0]          readWord;
    logic [7:0]               laneByte;
    logic [15:0]              laneHalf;
    logic [31:0]              loadData;

    // Pop only when there is work and room for its completion
    assign accessTake = !accessEmpty && sweepDone && !resultFull;

    // Fill sweep, one word per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            sweepIdx  <= '0;
            sweepDone <= 1'b0;
        end else if (!sweepDone) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == memIndexWidth'(memWords - 1)) begin
                sweepDone <= 1'b1;
            end
        end
    end

    // Store lanes and value replicated across them
    always_comb begin
        case (access.funct3[1:0])
            2'b00: begin
                storeLanes = 4'b0001 << access.byteOffset;
                laneData   = {4{access.storeData[7:0]}};
            end
            2'b01: begin
                storeLanes = 4'b0011 << access.byteOffset;
                laneData   = {2{access.storeData[15:0]}};
            end
            default: begin
                storeLanes = 4'b1111;
                laneData   = access.storeData;
            end
        endcase
    end

    // Single write port shared by the sweep and stores
    always_comb begin
        if (!sweepDone) begin
            writeIndex = sweepIdx;
            writeWord  = 32'(sweepIdx) + 32'd3; // Index plus three
            writeLanes = 4'b1111;
        end else begin
            writeIndex = access.wordIndex;
            writeWord  = laneData;
            writeLanes = (accessTake && access.isStore && !access.fault) ? storeLanes : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (writeLanes[lane]) begin
                mem[writeIndex][lane] <= writeWord[lane];
            end
        end
    end

    // Load lane select and extension
    assign readWord = mem[access.wordIndex];
    assign laneByte = readWord[access.byteOffset];
    assign laneHalf = access.byteOffset[1] ? readWord[3:2] : readWord[1:0];

    always_comb begin
        case (access.funct3)
            sizeByte:  loadData = {{24{laneByte[7]}}, laneByte};
            sizeHalf:  loadData = {{16{laneHalf[15]}}, laneHalf};
            sizeWord:  loadData = readWord;
            sizeByteU: loadData = {24'd0, laneByte};
            sizeHalfU: loadData = {16'd0, laneHalf};
            default:   loadData = 32'd0; // Illegal code, already faulted
        endcase
    end

    // Completion strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            doneValid <= 1'b0;
        end else begin
            doneValid <= accessTake;
        end
    end

    // Completion payload, captured on the pop edge
    always_ff @(posedge clk) begin
        if (accessTake) begin
            done.tag     <= access.tag;
            done.isStore <= access.isStore;
            done.fault   <= access.fault;
            done.data    <= (access.isStore || access.fault) ? 32'd0 : loadData;
        end
    end

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/1ns

module loadStoreUnit
    import coreTypesPkg::*, memPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     issue,
    input  lsRequest request,
    output logic     ready,
    input  logic     cdbGrant,
    output logic     complete,
    output lsResult  result
);

    logic     accessValid;
    memAccess access;
    memAccess accessHead;
    logic     accessEmpty;
    logic     accessFull;
    logic     accessAlmostFull;
    logic     accessTake;
    logic     sweepDone;
    logic     doneValid;
    lsResult  done;
    logic     resultEmpty;
    logic     resultAlmostFull;

    // Room for one more issue, counting an access still in the address stage
    assign ready = sweepDone && (accessValid ? !accessAlmostFull : !accessFull);

    // Result leaves whenever the arbiter grants the bus
    assign complete = !resultEmpty && cdbGrant;

    addressUnit addressUnit_inst (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .request     (request),
        .accessValid (accessValid),
        .access      (access)
    );

    opQueue #(
        .payloadType (memAccess),
        .depth       (accessQueueDepth)
    ) accessQueue (
        .clk        (clk),
        .reset      (reset),
        .push       (accessValid),
        .pushData   (access),
        .pop        (accessTake),
        .headData   (accessHead),
        .empty      (accessEmpty),
        .full       (accessFull),
        .almostFull (accessAlmostFull)
    );

    // Almost full leaves space for the completion already in flight
    dataMemory dataMemory_inst (
        .clk         (clk),
        .reset       (reset),
        .accessEmpty (accessEmpty),
        .access      (accessHead),
        .resultFull  (resultAlmostFull),
        .accessTake  (accessTake),
        .sweepDone   (sweepDone),
        .doneValid   (doneValid),
        .done        (done)
    );

    opQueue #(
        .payloadType (lsResult),
        .depth       (resultQueueDepth)
    ) resultQueue (
        .clk        (clk),
        .reset      (reset),
        .push       (doneValid),
        .pushData   (done),
        .pop        (complete),
        .headData   (result),
        .empty      (resultEmpty),
        .full       (),
        .almostFull (resultAlmostFull)
    );

endmodule

// ==== sim/loadStoreUnit_properties.sv ====
`timescale 1ns/1ns

module loadStoreUnitProperties
    import memPkg::*;
(
    input logic clk,
    input logic reset,
    input logic issue,
    input logic ready,
    input logic cdbGrant,
    input logic complete
);

    logic [$clog2(memWords+1)-1:0] sinceReset; // Saturates at memWords
    int                            failCount = 0; // Failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            sinceReset <= '0;
        end else if (sinceReset != memWords) begin
            sinceReset <= sinceReset + 1'b1;
        end
    end

    grantHeld: assert property (@(posedge clk) disable iff (reset) !cdbGrant |-> !complete)
        else begin
            $error("complete was high while cdbGrant was low");
            failCount++;
        end

    issueWhenReady: assert property (@(posedge clk) disable iff (reset) issue |-> ready)
        else begin
            $error("issue was pulsed while ready was low");
            failCount++;
        end

    // Sweep must finish before the first issue can be taken
    readyAfterSweep: assert property (@(posedge clk) disable iff (reset)
        (sinceReset < memWords) |-> !ready)
        else begin
            $error("ready rose before the fill sweep could finish");
            failCount++;
        end

    completeLowInReset: assert property (@(posedge clk) reset |=> !complete)
        else begin
            $error("complete was high coming out of reset");
            failCount++;
        end

endmodule

bind loadStoreUnit loadStoreUnitProperties loadStoreUnitProperties_inst (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .ready    (ready),
    .cdbGrant (cdbGrant),
    .complete (complete)
);

// ==== sim/loadStoreUnitTb.sv ====
`timescale 1ns/1ns

module loadStoreUnitTb
    import coreTypesPkg::*, memPkg::*;
();

    localparam int          clkPeriod      = 40;
    localparam int          plannedOps     = 400;
    localparam longint      watchdogCycles = memWords + 4 + plannedOps * 20;
    localparam logic [2:0]  illegalCodes [3] = '{3'b011, 3'b110, 3'b111};

    logic     clk;
    logic     reset;
    logic     issue;
    lsRequest request;
    logic     ready;
    logic     cdbGrant;
    logic     complete;
    lsResult  result;

    logic [31:0] refMem [memWords]; // Reference copy of the data memory
    lsResult     expQueue [$];      // Expected results in issue order
    lsResult     expHead;
    instTag      nextTag;
    logic        stallActive;
    logic        sawBackPressure;

    loadStoreUnit loadStoreUnit_inst (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .request  (request),
        .ready    (ready),
        .cdbGrant (cdbGrant),
        .complete (complete),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        abortRun("Watchdog expired before all operations completed");
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped");
    endtask

    // Expected completion from the reference memory, updates it for good stores
    task automatic modelOperation(input lsRequest req, output lsResult exp);
        logic [31:0]              addr;
        logic [memIndexWidth-1:0] idx;
        logic [4:0]               shift;
        logic [31:0]              word;
        logic [7:0]               byteVal;
        logic [15:0]              halfVal;
        logic                     bad;
        addr    = req.base + req.offset;
        idx     = addr[12:2]; // Upper address bits wrap
        shift   = {addr[1:0], 3'b000};
        word    = refMem[idx];
        byteVal = word[shift +: 8];
        halfVal = word[{addr[1], 4'b0000} +: 16];
        case (req.funct3)
            sizeByte, sizeByteU: bad = 1'b0;
            sizeHalf, sizeHalfU: bad = addr[0];
            sizeWord:            bad = (addr[1:0] != 2'b00);
            default:             bad = 1'b1;
        endcase
        exp.tag     = req.tag;
        exp.isStore = req.isStore;
        exp.fault   = bad;
        exp.data    = 32'd0;
        if (!bad && req.isStore) begin
            case (req.funct3)
                sizeByte: word[shift +: 8] = req.storeData[7:0];
                sizeHalf: word[shift +: 16] = req.storeData[15:0];
                sizeWord: word = req.storeData;
                default:  word = word; // Unsigned codes are never stored
            endcase
            refMem[idx] = word;
        end else if (!bad) begin
            case (req.funct3)
                sizeByte:  exp.data = {{24{byteVal[7]}}, byteVal};
                sizeHalf:  exp.data = {{16{halfVal[15]}}, halfVal};
                sizeByteU: exp.data = {24'd0, byteVal};
                sizeHalfU: exp.data = {16'd0, halfVal};
                default:   exp.data = word;
            endcase
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the issue
    task automatic issueOp(input logic [2:0] funct3, input logic isStore,
                           input logic [31:0] addr, input logic [31:0] data);
        lsRequest req;
        lsResult  exp;
        while (!ready) begin
            @(negedge clk);
        end
        req.tag       = nextTag;
        req.funct3    = funct3;
        req.isStore   = isStore;
        req.base      = $urandom;
        req.offset    = addr - req.base; // Random split of the same address
        req.storeData = data;
        nextTag       = nextTag + 1'b1;
        modelOperation(req, exp);
        expQueue.push_back(exp);
        request = req;
        issue   = 1'b1;
        @(negedge clk);
        issue = 1'b0;
    endtask

    // One store followed by every load size on the same word
    task automatic storeThenLoads(input logic [2:0] funct3, input int lane);
        logic [31:0] wordAddr;
        wordAddr = 32'h0000_00a0;
        issueOp(funct3, 1'b1, wordAddr + lane, $urandom);
        issueOp(sizeWord, 1'b0, wordAddr, 32'd0);
        for (int l = 0; l < 4; l++) begin
            issueOp(sizeByte, 1'b0, wordAddr + l, 32'd0);
            issueOp(sizeByteU, 1'b0, wordAddr + l, 32'd0);
        end
        for (int h = 0; h < 4; h += 2) begin
            issueOp(sizeHalf, 1'b0, wordAddr + h, 32'd0);
            issueOp(sizeHalfU, 1'b0, wordAddr + h, 32'd0);
        end
    endtask

    // Mixed access in a 16-word window so loads often hit recent stores
    task automatic issueRandomOp();
        logic [2:0]  funct3;
        logic        isStore;
        logic [1:0]  lane;
        logic [31:0] addr;
        isStore = $urandom_range(0, 1);
        case ($urandom_range(0, 9))
            0, 1, 2: funct3 = sizeByte;
            3, 4:    funct3 = sizeHalf;
            5, 6:    funct3 = sizeWord;
            7:       funct3 = isStore ? sizeByte : sizeByteU;
            8:       funct3 = isStore ? sizeHalf : sizeHalfU;
            default: funct3 = illegalCodes[$urandom_range(0, 2)];
        endcase
        lane = $urandom_range(0, 3);
        if ($urandom_range(0, 7) != 0) begin
            if (funct3 == sizeWord) begin
                lane = 2'd0;
            end else if (funct3 == sizeHalf || funct3 == sizeHalfU) begin
                lane[0] = 1'b0;
            end
        end
        addr = ($urandom & 32'hffff_e000) | ((32'd100 + $urandom_range(0, 15)) << 2) | lane;
        issueOp(funct3, isStore, addr, $urandom);
    endtask

    // Result checking against the head of the expected queue
    always @(posedge clk) begin
        if (stallActive && !ready) begin
            sawBackPressure = 1'b1;
        end
        if (!reset && complete) begin
            if (expQueue.size() != 0) begin
                expHead = expQueue.pop_front();
                assert (result === expHead) else begin
                    abortRun($sformatf({"ERROR at %0t ns: got tag %0d data %08h store %b ",
                        "fault %b, expected tag %0d data %08h store %b fault %b"}, $time,
                        result.tag, result.data, result.isStore, result.fault, expHead.tag,
                        expHead.data, expHead.isStore, expHead.fault));
                end
            end else begin
                abortRun($sformatf("Completion with tag %0d came with nothing outstanding",
                    result.tag));
            end
        end
    end

    // Protocol assertions of the bound checker
    always @(negedge clk) begin
        if (loadStoreUnit_inst.loadStoreUnitProperties_inst.failCount != 0) begin
            abortRun("A protocol assertion on the DUT ports failed");
        end
    end

    initial begin
        int drainCycles;
        void'($urandom(32'hfb9c9a18));
        issue           = 1'b0;
        request         = '0;
        cdbGrant        = 1'b0;
        reset           = 1'b1;
        stallActive     = 1'b0;
        sawBackPressure = 1'b0;
        nextTag         = $urandom;
        for (int i = 0; i < memWords; i++) begin
            refMem[i] = i + 3; // Fill pattern of the sweep
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        cdbGrant = 1'b1;
        assert (!ready && !complete) else abortRun("ready or complete high after reset");

        repeat (20) begin
            issueOp(sizeWord, 1'b0, $urandom & 32'hffff_fffc, 32'd0);
        end
        for (int lane = 0; lane < 4; lane++) begin
            storeThenLoads(sizeByte, lane);
        end
        storeThenLoads(sizeHalf, 0);
        storeThenLoads(sizeHalf, 2);
        storeThenLoads(sizeWord, 0);

        // Faulting accesses on word 60, then a check that it is untouched
        issueOp(sizeHalf, 1'b1, 32'h0000_00f1, $urandom);
        issueOp(sizeHalfU, 1'b0, 32'h0000_00f3, 32'd0);
        issueOp(sizeWord, 1'b1, 32'h0000_00f2, $urandom);
        issueOp(sizeWord, 1'b0, 32'h0000_00f1, 32'd0);
        for (int c = 0; c < 3; c++) begin
            issueOp(illegalCodes[c], 1'b1, 32'h0000_00f0, $urandom);
            issueOp(illegalCodes[c], 1'b0, 32'h0000_00f0, 32'd0);
        end
        issueOp(sizeWord, 1'b0, 32'h0000_00f0, 32'd0);

        repeat (150) begin
            issueRandomOp();
        end

        stallActive = 1'b1;
        fork
            while (stallActive) begin
                cdbGrant = 1'b0;
                repeat ($urandom_range(10, 40)) @(negedge clk);
                cdbGrant = 1'b1;
                repeat ($urandom_range(1, 6)) @(negedge clk);
            end
        join_none
        repeat (100) begin
            issueRandomOp();
        end
        stallActive = 1'b0;
        assert (sawBackPressure) else abortRun("ready never fell while the bus was stalled");

        drainCycles = 0;
        while (expQueue.size() != 0 && drainCycles < 200) begin
            @(negedge clk);
            drainCycles++;
        end
        repeat (10) @(negedge clk); // Room for a stray extra completion
        if (expQueue.size() != 0) begin
            abortRun($sformatf("%0d results never completed", expQueue.size()));
        end else if (loadStoreUnit_inst.loadStoreUnitProperties_inst.failCount != 0) begin
            abortRun("A protocol assertion on the DUT ports failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
src/coreTypesPkg.sv
src/memPkg.sv
src/addressUnit.sv
src/opQueue.sv
src/dataMemory.sv
src/loadStoreUnit.sv
sim/loadStoreUnit_properties.sv
sim/loadStoreUnitTb.sv
